// File: project.f
+incdir+dv
hdl/fbuf_pkg.sv
hdl/fbuf_ram.sv
hdl/fbuf_desc_fifo.sv
hdl/fbuf_wr_ctrl.sv
hdl/fbuf_rd_ctrl.sv
hdl/fbuf_top.sv
dv/fbuf_chk.sv
dv/fbuf_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP      := fbuf_tb
FILELIST := project.f
OBJ_DIR  := obj_dir
PASS_MSG := Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/fbuf_tests.svh
////////////////////
// frame driver
////////////////////

// smd and fragment strobes go with the first byte
task automatic send_frame(
    input smd_t     smd_code,
    input logic     smd_on,
    input byte_t    frag_in,
    input logic     frag_on,
    input int       n_bytes,
    input logic     crc_bad,
    input crc_vld_t crc_flags,
    input logic     room
);
    byte_t data;
    int    i;
    if (smd_on) begin
        model_smd = smd_code;
    end
    // start smd wins over a fragment code
    if (smd_on && is_start_smd(smd_code)) begin
        model_frag = 2'd0;
    end else if (frag_on) begin
        model_frag = decode_frag(frag_in, model_frag);
    end
    for (i = 0; i < n_bytes; i++) begin
        @(posedge clk);
        #DRV_DLY;
        data = next_byte();
        rx.data = data;
        rx.last = (i == n_bytes - 1);
        rx_vld = 1'b1;
        smd = smd_code;
        smd_vld = (i == 0) && smd_on;
        frag_code = frag_in;
        frag_vld = (i == 0) && frag_on;
        rx_end.crc_err = (i == n_bytes - 1) ? crc_bad : 1'b0;
        rx_end.crc_vld = (i == n_bytes - 1) ? crc_flags : 2'b00;
        if (!crc_bad && room) begin
            exp_data_q.push_back(data);
        end
    end
    // good frame with room in the fifo is expected out
    if (!crc_bad && room) begin
        exp_user_q.push_back({1'b1, model_smd, model_frag, crc_flags, 3'b000});
        exp_len_q.push_back(len_t'(n_bytes));
        frames_exp++;
    end
endtask

task automatic end_rx();
    @(posedge clk);
    #DRV_DLY;
    rx = '0;
    rx_vld = 1'b0;
    rx_end = '0;
    smd_vld = 1'b0;
    frag_vld = 1'b0;
endtask

task automatic wait_drain();
    while (exp_len_q.size() != 0) begin
        @(posedge clk);
    end
    repeat (8) @(posedge clk);
endtask

////////////////////
// directed tests
////////////////////

task automatic single_frame_roundtrip();
    send_frame(SMD_S0, 1'b1, FRAG_C0, 1'b1, 16, 1'b0, 2'b01, 1'b1);
    end_rx();
    wait_drain();
endtask

// bad frame bytes get overwritten by the next one
task automatic crc_error_rewind();
    send_frame(SMD_S1, 1'b1, FRAG_C0, 1'b0, 12, 1'b1, 2'b00, 1'b1);
    send_frame(8'h61, 1'b1, FRAG_C1, 1'b1, 10, 1'b0, 2'b11, 1'b1);
    end_rx();
    wait_drain();
endtask

task automatic user_word_rules();
    // start smd clears the fragment left by the rewind test
    send_frame(SMD_S1, 1'b1, 8'h00, 1'b0, 3, 1'b0, 2'b10, 1'b1);
    // continuation smd takes the fragment code
    send_frame(8'h61, 1'b1, FRAG_C2, 1'b1, 3, 1'b0, 2'b11, 1'b1);
    send_frame(8'h61, 1'b0, FRAG_C3, 1'b1, 3, 1'b0, 2'b01, 1'b1);
    send_frame(8'h52, 1'b1, 8'h00, 1'b0, 3, 1'b0, 2'b00, 1'b1);
    send_frame(8'h52, 1'b0, FRAG_C1, 1'b1, 3, 1'b0, 2'b01, 1'b1);
    // unknown code
    send_frame(8'h52, 1'b0, 8'h5a, 1'b1, 3, 1'b0, 2'b10, 1'b1);
    send_frame(8'h9e, 1'b1, FRAG_C0, 1'b1, 3, 1'b0, 2'b11, 1'b1);
    send_frame(8'h9e, 1'b0, FRAG_C3, 1'b1, 3, 1'b0, 2'b01, 1'b1);
    // start smd alone clears a nonzero fragment
    send_frame(SMD_S2, 1'b1, 8'h00, 1'b0, 3, 1'b0, 2'b01, 1'b1);
    send_frame(8'h2a, 1'b1, FRAG_C2, 1'b1, 3, 1'b0, 2'b10, 1'b1);
    send_frame(SMD_S3, 1'b1, FRAG_C2, 1'b1, 3, 1'b0, 2'b11, 1'b1);
    end_rx();
    wait_drain();
endtask

task automatic back_to_back_frames();
    send_frame(SMD_S0, 1'b1, FRAG_C0, 1'b0, 7, 1'b0, 2'b01, 1'b1);
    send_frame(SMD_S0, 1'b0, FRAG_C1, 1'b1, 1, 1'b0, 2'b01, 1'b1);
    send_frame(SMD_S0, 1'b0, FRAG_C2, 1'b1, 3, 1'b0, 2'b10, 1'b1);
    send_frame(SMD_S0, 1'b0, FRAG_C3, 1'b1, 12, 1'b0, 2'b11, 1'b1);
    // s0 clears the fragment left by c3
    send_frame(SMD_S0, 1'b1, FRAG_C0, 1'b0, 5, 1'b0, 2'b01, 1'b1);
    end_rx();
    wait_drain();
endtask

// long frame keeps the reader busy while short ones fill the fifo
task automatic fifo_overflow_drop();
    int i;
    send_frame(SMD_S2, 1'b1, FRAG_C0, 1'b0, 100, 1'b0, 2'b01, 1'b1);
    for (i = 0; i < FIFO_DEPTH_DEF + 4; i++) begin
        send_frame(SMD_S2, 1'b0, FRAG_C0, 1'b0, 2, 1'b0, 2'b01, i < FIFO_DEPTH_DEF);
    end
    end_rx();
    wait_drain();
endtask

// File: dv/fbuf_tb.sv
`timescale 1ns/1ps

module fbuf_tb import fbuf_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam int RST_CYCLES = 16;
    localparam int DRV_DLY    = 1;
    localparam logic [31:0] LFSR_SEED = 32'h84e50292;
    // bytes over all tests 16, 12+10, 11*3, 7+1+3+12+5, 100+20*2
    localparam int TEST_BYTES = 239;
    localparam int WATCHDOG_CYCLES = TEST_BYTES * 4 + RST_CYCLES + 600;

    logic     clk;
    logic     rst;
    rx_beat_t rx;
    logic     rx_vld;
    rx_end_t  rx_end;
    smd_t     smd;
    logic     smd_vld;
    byte_t    frag_code;
    logic     frag_vld;
    tx_beat_t tx;
    logic     tx_vld;

    // reference model of the latched smd and fragment number
    smd_t        model_smd;
    frag_t       model_frag;
    logic [31:0] lfsr_state = LFSR_SEED;

    // scoreboard of bytes and per frame user words and lengths
    byte_t exp_data_q [$];
    user_t exp_user_q [$];
    len_t  exp_len_q  [$];
    int    frames_exp;
    int    frames_seen;
    // collector state
    int    beat_idx;
    bit    gap_due;

    fbuf_top #(
        .RAM_DEPTH  (RAM_DEPTH_DEF),
        .FIFO_DEPTH (FIFO_DEPTH_DEF)
    ) dut_i (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_rx        (rx),
        .i_rx_vld    (rx_vld),
        .i_rx_end    (rx_end),
        .i_smd       (smd),
        .i_smd_vld   (smd_vld),
        .i_frag_code (frag_code),
        .i_frag_vld  (frag_vld),
        .o_tx        (tx),
        .o_tx_vld    (tx_vld)
    );

    bind fbuf_top fbuf_chk chk_i (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_tx     (o_tx),
        .i_tx_vld (o_tx_vld)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////
    // failure and compare
    ////////////////////

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_byte(input string what, input byte_t exp, input byte_t got);
        if (got !== exp) begin
            fail_stop($sformatf("Mismatch at %0t: %s expected %h got %h", $time, what, exp, got));
        end
    endtask

    task automatic check_user(input string what, input user_t exp, input user_t got);
        if (got !== exp) begin
            fail_stop($sformatf("Mismatch at %0t: %s expected %h got %h", $time, what, exp, got));
        end
    endtask

    task automatic check_len(input string what, input len_t exp, input len_t got);
        if (got !== exp) begin
            fail_stop($sformatf("Mismatch at %0t: %s expected %0d got %0d", $time, what, exp, got));
        end
    endtask

    task automatic check_last(input string what, input logic exp, input logic got);
        if (got !== exp) begin
            fail_stop($sformatf("Mismatch at %0t: %s expected %b got %b", $time, what, exp, got));
        end
    endtask

    ////////////////////
    // stimulus helpers
    ////////////////////

    // fibonacci lfsr with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per payload bit
    function automatic byte_t next_byte();
        byte_t b;
        int    k;
        b = '0;
        for (k = 0; k < 8; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
        return b;
    endfunction

    function automatic logic is_start_smd(input smd_t s);
        return (s == SMD_S0) || (s == SMD_S1) || (s == SMD_S2) || (s == SMD_S3);
    endfunction

    // unknown codes leave the number alone
    function automatic frag_t decode_frag(input byte_t code, input frag_t prev);
        case (code)
            FRAG_C0: return 2'd0;
            FRAG_C1: return 2'd1;
            FRAG_C2: return 2'd2;
            FRAG_C3: return 2'd3;
            default: return prev;
        endcase
    endfunction

    `include "fbuf_tests.svh"

    ////////////////////
    // output collector
    ////////////////////

    task automatic take_beat();
        byte_t exp_data;
        logic  end_of_frame;
        if (exp_len_q.size() == 0) begin
            fail_stop("Error: output beat while no frame was expected");
        end else begin
            exp_data = exp_data_q.pop_front();
            end_of_frame = (beat_idx == int'(exp_len_q[0]) - 1);
            check_byte("data", exp_data, tx.data);
            check_user("user", exp_user_q[0], tx.user);
            check_len("len", exp_len_q[0], tx.len);
            check_last("last", end_of_frame, tx.last);
            if (end_of_frame) begin
                void'(exp_user_q.pop_front());
                void'(exp_len_q.pop_front());
                frames_seen++;
                beat_idx = 0;
                gap_due = 1'b1;
            end else begin
                beat_idx++;
            end
        end
    endtask

    // outputs are sampled on the falling edge where they are stable
    always @(negedge clk) begin
        if (rst) begin
            if (tx_vld) begin
                fail_stop("Error: output strobe high during reset");
            end
        end else begin
            if (tx_vld && gap_due) begin
                fail_stop("Error: no idle cycle after the end of a frame");
            end
            if (!tx_vld && beat_idx != 0) begin
                fail_stop("Error: output strobe dropped in the middle of a frame");
            end
            gap_due = 1'b0;
            if (tx_vld) begin
                take_beat();
            end
        end
    end

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        $timeformat(-9, 0, " ns", 0);
        clk = 1'b0;
        rst = 1'b1;
        rx = '0;
        rx_vld = 1'b0;
        rx_end = '0;
        smd = '0;
        smd_vld = 1'b0;
        frag_code = '0;
        frag_vld = 1'b0;
        model_smd = '0;
        model_frag = '0;
        frames_exp = 0;
        frames_seen = 0;
        beat_idx = 0;
        gap_due = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #DRV_DLY;
        rst = 1'b0;
        repeat (4) @(posedge clk);
        single_frame_roundtrip();
        crc_error_rewind();
        user_word_rules();
        back_to_back_frames();
        fifo_overflow_drop();
        // any stray beat shows up in the collector here
        repeat (50) @(posedge clk);
        if (exp_len_q.size() == 0 && frames_seen == frames_exp) begin
            $display("Testbench passed");
            $finish;
        end else begin
            fail_stop($sformatf("Error: %0d of %0d expected frames came out",
                                frames_seen, frames_exp));
        end
    end

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_stop("Error: watchdog timeout, the DUT stopped delivering frames");
    end

endmodule

// File: dv/fbuf_chk.sv
`timescale 1ns/1ps

module fbuf_chk import fbuf_pkg::*; (
    input logic     i_clk,
    input logic     i_rst,
    input tx_beat_t i_tx,
    input logic     i_tx_vld
);

    ////////////////////
    // output protocol
    ////////////////////

    // quiet output in reset
    a_rst_quiet: assert property (@(posedge i_clk) i_rst |-> !i_tx_vld)
        else $error("output strobe high during reset");

    // one dead beat after each frame
    a_gap_after_last: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_tx_vld && i_tx.last) |=> !i_tx_vld)
        else $error("output strobe high right after a last beat");

    // contiguous beats, length held
    a_len_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_tx_vld && !i_tx.last) |=> (i_tx_vld && $stable(i_tx.len)))
        else $error("frame length changed or beats broke up inside a frame");

endmodule

// File: hdl/fbuf_top.sv
`timescale 1ns/1ps

module fbuf_top import fbuf_pkg::*; #(
    parameter int RAM_DEPTH  = RAM_DEPTH_DEF,
    parameter int FIFO_DEPTH = FIFO_DEPTH_DEF,
    localparam int RAM_AW    = $clog2(RAM_DEPTH)
) (
    input  logic     i_clk,
    input  logic     i_rst,
    input  rx_beat_t i_rx,
    input  logic     i_rx_vld,
    input  rx_end_t  i_rx_end,
    input  smd_t     i_smd,
    input  logic     i_smd_vld,
    input  byte_t    i_frag_code,
    input  logic     i_frag_vld,
    output tx_beat_t o_tx,
    output logic     o_tx_vld
);

    // ram write side
    logic              wr_en;
    logic [RAM_AW-1:0] wr_addr;
    byte_t             wr_data;
    // ram read side
    logic              rd_en;
    logic [RAM_AW-1:0] rd_addr;
    byte_t             rd_data;
    // descriptor path
    logic              push;
    logic              pop;
    desc_t             push_desc;
    desc_t             head_desc;
    logic              fifo_empty;
    logic              fifo_full;

    ////////////////////
    // write side
    ////////////////////

    fbuf_wr_ctrl #(
        .RAM_DEPTH  (RAM_DEPTH)
    ) wr_ctrl_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_rx        (i_rx),
        .i_rx_vld    (i_rx_vld),
        .i_rx_end    (i_rx_end),
        .i_smd       (i_smd),
        .i_smd_vld   (i_smd_vld),
        .i_frag_code (i_frag_code),
        .i_frag_vld  (i_frag_vld),
        .i_fifo_full (fifo_full),
        .o_wr_en     (wr_en),
        .o_wr_addr   (wr_addr),
        .o_wr_data   (wr_data),
        .o_push      (push),
        .o_desc      (push_desc)
    );

    // byte store
    fbuf_ram #(
        .RAM_DEPTH  (RAM_DEPTH)
    ) ram_i (
        .i_clk     (i_clk),
        .i_wr_en   (wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_data (wr_data),
        .i_rd_en   (rd_en),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data)
    );

    // committed frames
    fbuf_desc_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) desc_fifo_i (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_push  (push),
        .i_desc  (push_desc),
        .i_pop   (pop),
        .o_head  (head_desc),
        .o_empty (fifo_empty),
        .o_full  (fifo_full)
    );

    ////////////////////
    // read side
    ////////////////////

    fbuf_rd_ctrl #(
        .RAM_DEPTH  (RAM_DEPTH)
    ) rd_ctrl_i (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_head    (head_desc),
        .i_empty   (fifo_empty),
        .o_pop     (pop),
        .o_rd_en   (rd_en),
        .o_rd_addr (rd_addr),
        .i_rd_data (rd_data),
        .o_tx      (o_tx),
        .o_tx_vld  (o_tx_vld)
    );

endmodule

// File: hdl/fbuf_rd_ctrl.sv
`timescale 1ns/1ps

module fbuf_rd_ctrl import fbuf_pkg::*; #(
    parameter int RAM_DEPTH = RAM_DEPTH_DEF,
    localparam int RAM_AW   = $clog2(RAM_DEPTH)
) (
    input  logic              i_clk,
    input  logic              i_rst,
    input  desc_t             i_head,
    input  logic              i_empty,
    output logic              o_pop,
    output logic              o_rd_en,
    output logic [RAM_AW-1:0] o_rd_addr,
    input  byte_t             i_rd_data,
    output tx_beat_t          o_tx,
    output logic              o_tx_vld
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_STREAM,
        ST_GAP
    } rd_state_t;

    rd_state_t         state;
    logic [RAM_AW-1:0] rd_ptr;
    // reads left after the current one
    len_t              cnt;
    logic              final_rd;
    logic              rd_vld_q;
    logic              last_q;
    user_t             user_q;
    len_t              len_q;

    ////////////////////
    // read side decode
    ////////////////////

    // load pops the head and issues its first address
    assign o_pop     = (state == ST_LOAD);
    assign o_rd_en   = (state == ST_LOAD) || (state == ST_STREAM);
    assign o_rd_addr = (state == ST_LOAD) ? RAM_AW'(i_head.addr) : rd_ptr;
    assign final_rd  = ((state == ST_LOAD) && (i_head.len == len_t'(1))) ||
                       ((state == ST_STREAM) && (cnt == len_t'(1)));

    ////////////////////
    // state machine
    ////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state    <= ST_IDLE;
            rd_ptr   <= '0;
            cnt      <= '0;
            rd_vld_q <= 1'b0;
            last_q   <= 1'b0;
        end else begin
            rd_vld_q <= o_rd_en;
            last_q   <= o_rd_en && final_rd;
            // next address, wrap at ram depth
            if (o_rd_en) begin
                rd_ptr <= (o_rd_addr == RAM_AW'(RAM_DEPTH - 1)) ? '0 : o_rd_addr + 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    if (!i_empty) begin
                        state <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    cnt   <= i_head.len - 1'b1;
                    state <= final_rd ? ST_GAP : ST_STREAM;
                end
                ST_STREAM: begin
                    cnt <= cnt - 1'b1;
                    if (final_rd) begin
                        state <= ST_GAP;
                    end
                end
                // one dead beat, then straight on if more queued
                ST_GAP: begin
                    state <= i_empty ? ST_IDLE : ST_LOAD;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // frame side info, held for the whole frame
    always_ff @(posedge i_clk) begin
        if (state == ST_LOAD) begin
            user_q <= {1'b1, i_head.smd, i_head.frag, i_head.crc_vld, 3'b000};
            len_q  <= i_head.len;
        end
    end

    ////////////////////
    // output beat
    ////////////////////

    assign o_tx_vld = rd_vld_q;

    always_comb begin
        o_tx.data = rd_vld_q ? i_rd_data : '0;
        o_tx.last = last_q;
        o_tx.user = user_q;
        o_tx.len  = len_q;
    end

endmodule

// File: hdl/fbuf_wr_ctrl.sv
`timescale 1ns/1ps

module fbuf_wr_ctrl import fbuf_pkg::*; #(
    parameter int RAM_DEPTH = RAM_DEPTH_DEF,
    localparam int RAM_AW   = $clog2(RAM_DEPTH)
) (
    input  logic              i_clk,
    input  logic              i_rst,
    input  rx_beat_t          i_rx,
    input  logic              i_rx_vld,
    input  rx_end_t           i_rx_end,
    input  smd_t              i_smd,
    input  logic              i_smd_vld,
    input  byte_t             i_frag_code,
    input  logic              i_frag_vld,
    input  logic              i_fifo_full,
    output logic              o_wr_en,
    output logic [RAM_AW-1:0] o_wr_addr,
    output byte_t             o_wr_data,
    output logic              o_push,
    output desc_t             o_desc
);

    // input stage
    logic              wr_en_q;
    logic              last_q;
    byte_t             wr_data_q;
    rx_end_t           end_q;
    // pointers and frame state
    logic [RAM_AW-1:0] wr_ptr;
    logic [RAM_AW-1:0] wr_ptr_inc;
    logic [RAM_AW-1:0] start_ptr;
    len_t              len_cnt;
    smd_t              smd_q;
    frag_t             frag_q;
    logic              smd_is_start;

    ////////////////////
    // input register
    ////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            wr_en_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            wr_en_q <= i_rx_vld;
            last_q  <= i_rx_vld && i_rx.last;
        end
    end

    // byte and crc result
    always_ff @(posedge i_clk) begin
        wr_data_q <= i_rx.data;
        if (i_rx_vld && i_rx.last) begin
            end_q <= i_rx_end;
        end
    end

    ////////////////////
    // write pointer
    ////////////////////

    // wrap at ram depth
    assign wr_ptr_inc = (wr_ptr == RAM_AW'(RAM_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;

    // commit only on good crc with room in the fifo
    assign o_push = last_q && !end_q.crc_err && !i_fifo_full;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            wr_ptr    <= '0;
            start_ptr <= '0;
            len_cnt   <= '0;
        end else if (wr_en_q) begin
            // bad or dropped frame, back to its first byte
            if (last_q && !o_push) begin
                wr_ptr <= start_ptr;
            end else begin
                wr_ptr <= wr_ptr_inc;
            end
            if (o_push) begin
                start_ptr <= wr_ptr_inc;
            end
            len_cnt <= last_q ? '0 : len_cnt + 1'b1;
        end
    end

    ////////////////////
    // smd and fragment
    ////////////////////

    assign smd_is_start = i_smd inside {SMD_S0, SMD_S1, SMD_S2, SMD_S3};

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            smd_q  <= '0;
            frag_q <= '0;
        end else begin
            if (i_smd_vld) begin
                smd_q <= i_smd;
            end
            // start smd restarts the fragment number
            if (i_smd_vld && smd_is_start) begin
                frag_q <= 2'd0;
            end else if (i_frag_vld) begin
                case (i_frag_code)
                    FRAG_C0: frag_q <= 2'd0;
                    FRAG_C1: frag_q <= 2'd1;
                    FRAG_C2: frag_q <= 2'd2;
                    FRAG_C3: frag_q <= 2'd3;
                    default: frag_q <= frag_q;
                endcase
            end
        end
    end

    // ram port
    assign o_wr_en   = wr_en_q;
    assign o_wr_addr = wr_ptr;
    assign o_wr_data = wr_data_q;

    // descriptor, length counts the byte written now
    always_comb begin
        o_desc.addr    = addr_t'(start_ptr);
        o_desc.len     = len_cnt + 1'b1;
        o_desc.smd     = smd_q;
        o_desc.frag    = frag_q;
        o_desc.crc_vld = end_q.crc_vld;
    end

endmodule

// File: hdl/fbuf_desc_fifo.sv
`timescale 1ns/1ps

module fbuf_desc_fifo import fbuf_pkg::*; #(
    parameter int FIFO_DEPTH = FIFO_DEPTH_DEF,
    localparam int FIFO_AW   = $clog2(FIFO_DEPTH),
    localparam int CNT_W     = $clog2(FIFO_DEPTH + 1)
) (
    input  logic  i_clk,
    input  logic  i_rst,
    input  logic  i_push,
    input  desc_t i_desc,
    input  logic  i_pop,
    output desc_t o_head,
    output logic  o_empty,
    output logic  o_full
);

    desc_t              mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               push_ok;
    logic               pop_ok;

    // guarded requests
    assign push_ok = i_push && !o_full;
    assign pop_ok  = i_pop && !o_empty;

    assign o_empty = (count == '0);
    assign o_full  = (count == CNT_W'(FIFO_DEPTH));

    // head shows without a read request
    assign o_head = mem[rd_ptr];

    ////////////////////
    // storage
    ////////////////////

    always_ff @(posedge i_clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= i_desc;
        end
    end

    ////////////////////
    // pointers and count
    ////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == FIFO_AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == FIFO_AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop keeps the count
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: hdl/fbuf_ram.sv
`timescale 1ns/1ps

module fbuf_ram import fbuf_pkg::*; #(
    parameter int RAM_DEPTH = RAM_DEPTH_DEF,
    localparam int RAM_AW   = $clog2(RAM_DEPTH)
) (
    input  logic              i_clk,
    input  logic              i_wr_en,
    input  logic [RAM_AW-1:0] i_wr_addr,
    input  byte_t             i_wr_data,
    input  logic              i_rd_en,
    input  logic [RAM_AW-1:0] i_rd_addr,
    output byte_t             o_rd_data
);

    // frame byte store
    byte_t mem [RAM_DEPTH];

    ////////////////////
    // write port
    ////////////////////

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    ////////////////////
    // read port
    ////////////////////

    // one cycle read latency
    always_ff @(posedge i_clk) begin
        if (i_rd_en) begin
            o_rd_data <= mem[i_rd_addr];
        end
    end

endmodule

// File: hdl/fbuf_pkg.sv
package fbuf_pkg;

    ////////////////////
    // widths with a meaning
    ////////////////////

    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  smd_t;
    // decoded fragment number, 0 to 3
    typedef logic [1:0]  frag_t;
    // bit 0 crc valid, bit 1 mcrc valid
    typedef logic [1:0]  crc_vld_t;
    typedef logic [11:0] len_t;
    // 1 flag, smd, frag, crc flags, 3 zeros
    typedef logic [15:0] user_t;

    // descriptor address field, sized for the default depth
    localparam int DESC_AW = 11;
    typedef logic [DESC_AW-1:0] addr_t;

    // default sizes
    localparam int RAM_DEPTH_DEF  = 2048;
    localparam int FIFO_DEPTH_DEF = 16;

    ////////////////////
    // smd and fragment codes
    ////////////////////

    // start smd of a new frame
    localparam smd_t SMD_S0 = 8'he6;
    localparam smd_t SMD_S1 = 8'h4c;
    localparam smd_t SMD_S2 = 8'h7f;
    localparam smd_t SMD_S3 = 8'hb3;

    // fragment count codes, decode to 0..3
    localparam byte_t FRAG_C0 = 8'he6;
    localparam byte_t FRAG_C1 = 8'h4c;
    localparam byte_t FRAG_C2 = 8'h7f;
    localparam byte_t FRAG_C3 = 8'hb3;

    ////////////////////
    // structs
    ////////////////////

    // one received byte
    typedef struct packed {
        byte_t data;
        logic  last;
    } rx_beat_t;

    // crc result, sampled with the last byte
    typedef struct packed {
        logic     crc_err;
        crc_vld_t crc_vld;
    } rx_end_t;

    // one stored frame
    typedef struct packed {
        addr_t    addr;
        len_t     len;
        smd_t     smd;
        frag_t    frag;
        crc_vld_t crc_vld;
    } desc_t;

    // one output beat
    typedef struct packed {
        byte_t data;
        logic  last;
        user_t user;
        len_t  len;
    } tx_beat_t;

endpackage
